// ==== common/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_RESET_PC  32'h1c00_0000
`define CPU_LINK_REG  5'd1

// Instruction word fields.
`define CPU_F_OP6     31:26
`define CPU_F_OP4     25:22
`define CPU_F_OP2     21:20
`define CPU_F_OP5     19:15
`define CPU_F_RD      4:0
`define CPU_F_RJ      9:5
`define CPU_F_RK      14:10
`define CPU_F_I12     21:10
`define CPU_F_I16     25:10
`define CPU_F_I20     24:5
`define CPU_F_I26_HI  9:0

`endif

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // One instruction walks these steps, IDLE only after reset.
    typedef enum logic [2:0] {
        STEP_IDLE,
        STEP_IF,
        STEP_ID,
        STEP_EXE,
        STEP_MEM,
        STEP_WB
    } step_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_JIRL
    } br_kind_t;

endpackage

// ==== common/dec_exe_if.sv ====
`timescale 1ns/1ps

interface dec_exe_if;

    cpu_pkg::alu_op_t  op;
    cpu_pkg::br_kind_t br;
    logic              src1_is_pc;
    logic              src2_is_imm;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    offs;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    cpu_pkg::reg_idx_t dest;

    modport source (output op, br, src1_is_pc, src2_is_imm, imm, offs,
                    mem_read, mem_write, reg_write, dest);

    modport exec (input op, br, src1_is_pc, src2_is_imm, imm, offs, mem_write);

    modport result (input br, mem_read, mem_write, reg_write, dest);

endinterface

// ==== decode/inst_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module inst_decoder (
    input  cpu_pkg::word_t    inst,
    dec_exe_if.source         dec,
    output cpu_pkg::reg_idx_t raddr1,
    output cpu_pkg::reg_idx_t raddr2
);

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_sh;
    logic        inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;

    assign op6 = inst[`CPU_F_OP6];
    assign op4 = inst[`CPU_F_OP4];
    assign op2 = inst[`CPU_F_OP2];
    assign op5 = inst[`CPU_F_OP5];
    assign rd  = inst[`CPU_F_RD];
    assign rj  = inst[`CPU_F_RJ];
    assign rk  = inst[`CPU_F_RK];
    assign i12 = inst[`CPU_F_I12];
    assign i16 = inst[`CPU_F_I16];
    assign i20 = inst[`CPU_F_I20];
    assign i26 = {inst[`CPU_F_I26_HI], inst[`CPU_F_I16]};

    // ***********************************************************************
    // Instruction match.
    // ***********************************************************************
    assign is_3r = (op6 == 6'h00) && (op4 == 4'h0) && (op2 == 2'h1);
    assign is_sh = (op6 == 6'h00) && (op4 == 4'h1) && (op2 == 2'h0);

    assign inst_sub_w   = is_3r && (op5 == 5'h02);
    assign inst_slt     = is_3r && (op5 == 5'h04);
    assign inst_sltu    = is_3r && (op5 == 5'h05);
    assign inst_nor     = is_3r && (op5 == 5'h08);
    assign inst_and     = is_3r && (op5 == 5'h09);
    assign inst_or      = is_3r && (op5 == 5'h0a);
    assign inst_xor     = is_3r && (op5 == 5'h0b);
    assign inst_slli_w  = is_sh && (op5 == 5'h01);
    assign inst_srli_w  = is_sh && (op5 == 5'h09);
    assign inst_srai_w  = is_sh && (op5 == 5'h11);
    assign inst_addi_w  = (op6 == 6'h00) && (op4 == 4'ha);
    assign inst_ld_w    = (op6 == 6'h0a) && (op4 == 4'h2);
    assign inst_st_w    = (op6 == 6'h0a) && (op4 == 4'h6);
    assign inst_jirl    = (op6 == 6'h13);
    assign inst_b       = (op6 == 6'h14);
    assign inst_bl      = (op6 == 6'h15);
    assign inst_beq     = (op6 == 6'h16);
    assign inst_bne     = (op6 == 6'h17);
    assign inst_lu12i_w = (op6 == 6'h05) && !inst[25];

    always_comb begin
        dec.op = cpu_pkg::ALU_ADD;
        if (inst_sub_w)   dec.op = cpu_pkg::ALU_SUB;
        if (inst_slt)     dec.op = cpu_pkg::ALU_SLT;
        if (inst_sltu)    dec.op = cpu_pkg::ALU_SLTU;
        if (inst_and)     dec.op = cpu_pkg::ALU_AND;
        if (inst_nor)     dec.op = cpu_pkg::ALU_NOR;
        if (inst_or)      dec.op = cpu_pkg::ALU_OR;
        if (inst_xor)     dec.op = cpu_pkg::ALU_XOR;
        if (inst_slli_w)  dec.op = cpu_pkg::ALU_SLL;
        if (inst_srli_w)  dec.op = cpu_pkg::ALU_SRL;
        if (inst_srai_w)  dec.op = cpu_pkg::ALU_SRA;
        if (inst_lu12i_w) dec.op = cpu_pkg::ALU_LUI;
    end

    always_comb begin
        dec.br = cpu_pkg::BR_NONE;
        if (inst_b)    dec.br = cpu_pkg::BR_B;
        if (inst_bl)   dec.br = cpu_pkg::BR_BL;
        if (inst_beq)  dec.br = cpu_pkg::BR_BEQ;
        if (inst_bne)  dec.br = cpu_pkg::BR_BNE;
        if (inst_jirl) dec.br = cpu_pkg::BR_JIRL;
    end

    // Link instructions compute pc + 4 through the ALU.
    assign dec.imm = (inst_bl || inst_jirl)                  ? 32'h4 :
                     inst_lu12i_w                            ? {i20, 12'b0} :
                     (inst_slli_w || inst_srli_w || inst_srai_w) ? {27'b0, rk} :
                     {{20{i12[11]}}, i12};

    assign dec.offs = (inst_b || inst_bl) ? {{4{i26[25]}}, i26, 2'b00} :
                                            {{14{i16[15]}}, i16, 2'b00};

    assign dec.src1_is_pc  = inst_bl || inst_jirl;
    assign dec.src2_is_imm = inst_slli_w || inst_srli_w || inst_srai_w || inst_addi_w
                           || inst_lu12i_w || inst_ld_w || inst_st_w || inst_bl || inst_jirl;

    assign dec.mem_read  = inst_ld_w;
    assign dec.mem_write = inst_st_w;
    assign dec.reg_write = is_3r || is_sh || inst_addi_w || inst_lu12i_w || inst_ld_w
                         || inst_bl || inst_jirl;
    assign dec.dest      = inst_bl ? `CPU_LINK_REG : rd;

    assign raddr1 = rj;
    assign raddr2 = (inst_beq || inst_bne || inst_st_w) ? rd : rk;

endmodule

// ==== execute/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    dec_exe_if.exec         dec,
    input  cpu_pkg::word_t  pc,
    input  cpu_pkg::step_t  step,
    input  cpu_pkg::word_t  rdata1,
    input  cpu_pkg::word_t  rdata2,
    output cpu_pkg::word_t  alu_result,
    output logic            data_we,
    output cpu_pkg::word_t  data_addr,
    output cpu_pkg::word_t  data_wdata,
    output logic            taken,
    output cpu_pkg::word_t  target
);

    cpu_pkg::word_t src1;
    cpu_pkg::word_t src2;
    logic [4:0]     sh;
    logic           regs_eq;

    assign src1 = dec.src1_is_pc  ? pc : rdata1;
    assign src2 = dec.src2_is_imm ? dec.imm : rdata2;
    assign sh   = src2[4:0];

    // ***********************************************************************
    // ALU.
    // ***********************************************************************
    always_comb begin
        case (dec.op)
            cpu_pkg::ALU_ADD:  alu_result = src1 + src2;
            cpu_pkg::ALU_SUB:  alu_result = src1 - src2;
            cpu_pkg::ALU_SLT:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
            cpu_pkg::ALU_SLTU: alu_result = {31'b0, src1 < src2};
            cpu_pkg::ALU_AND:  alu_result = src1 & src2;
            cpu_pkg::ALU_NOR:  alu_result = ~(src1 | src2);
            cpu_pkg::ALU_OR:   alu_result = src1 | src2;
            cpu_pkg::ALU_XOR:  alu_result = src1 ^ src2;
            cpu_pkg::ALU_SLL:  alu_result = src1 << sh;
            cpu_pkg::ALU_SRL:  alu_result = src1 >> sh;
            cpu_pkg::ALU_SRA:  alu_result = $signed(src1) >>> sh;
            cpu_pkg::ALU_LUI:  alu_result = src2;
            default:           alu_result = src1 + src2;
        endcase
    end

    // ***********************************************************************
    // Branch decision and target.
    // ***********************************************************************
    assign regs_eq = (rdata1 == rdata2);

    always_comb begin
        case (dec.br)
            cpu_pkg::BR_BEQ:  taken = regs_eq;
            cpu_pkg::BR_BNE:  taken = !regs_eq;
            cpu_pkg::BR_B,
            cpu_pkg::BR_BL,
            cpu_pkg::BR_JIRL: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign target = (dec.br == cpu_pkg::BR_JIRL) ? rdata1 + dec.offs : pc + dec.offs;

    // Store address is rj + si12, data comes from rd.
    assign data_addr  = alu_result;
    assign data_wdata = rdata2;
    assign data_we    = dec.mem_write && (step == cpu_pkg::STEP_MEM);

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t raddr1,
    input  cpu_pkg::reg_idx_t raddr2,
    input  logic              we,
    input  cpu_pkg::reg_idx_t waddr,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero whatever was written to it.
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

// ==== logic/step_control.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module step_control (
    input  logic            clk,
    input  logic            reset,
    input  cpu_pkg::word_t  inst_rdata,
    input  logic            taken,
    input  cpu_pkg::word_t  target,
    dec_exe_if.result       dec,
    output cpu_pkg::step_t  step,
    output cpu_pkg::word_t  pc,
    output cpu_pkg::word_t  inst
);

    cpu_pkg::step_t next_step;
    logic           cond_branch;

    assign cond_branch = (dec.br == cpu_pkg::BR_B) || (dec.br == cpu_pkg::BR_BEQ)
                       || (dec.br == cpu_pkg::BR_BNE);

    always_comb begin
        case (step)
            cpu_pkg::STEP_IDLE: next_step = cpu_pkg::STEP_IF;
            cpu_pkg::STEP_IF:   next_step = cpu_pkg::STEP_ID;
            cpu_pkg::STEP_ID:   next_step = cond_branch ? cpu_pkg::STEP_IF : cpu_pkg::STEP_EXE;
            cpu_pkg::STEP_EXE: begin
                if (dec.mem_read || dec.mem_write)
                    next_step = cpu_pkg::STEP_MEM;
                else
                    next_step = dec.reg_write ? cpu_pkg::STEP_WB : cpu_pkg::STEP_IF;
            end
            cpu_pkg::STEP_MEM:  next_step = dec.reg_write ? cpu_pkg::STEP_WB : cpu_pkg::STEP_IF;
            default:            next_step = cpu_pkg::STEP_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= cpu_pkg::STEP_IDLE;
            pc   <= `CPU_RESET_PC;
        end else begin
            step <= next_step;
            // The last step of an instruction moves the PC on.
            if (next_step == cpu_pkg::STEP_IF && step != cpu_pkg::STEP_IDLE) begin
                pc <= taken ? target : pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step == cpu_pkg::STEP_IF) begin
            inst <= inst_rdata;
        end
    end

endmodule

// ==== logic/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
    input  logic              clk,
    input  logic              reset,
    dec_exe_if.result         dec,
    input  cpu_pkg::step_t    step,
    input  cpu_pkg::word_t    pc,
    input  cpu_pkg::word_t    alu_result,
    input  cpu_pkg::word_t    data_rdata,
    output logic              rf_we,
    output cpu_pkg::reg_idx_t rf_waddr,
    output cpu_pkg::word_t    rf_wdata,
    output cpu_pkg::word_t    trace_pc,
    output logic              trace_we,
    output cpu_pkg::reg_idx_t trace_wnum,
    output cpu_pkg::word_t    trace_wdata
);

    cpu_pkg::word_t result;
    logic           wb_en;

    always_ff @(posedge clk) begin
        if (step == cpu_pkg::STEP_EXE)
            result <= alu_result;
        else if (step == cpu_pkg::STEP_MEM && dec.mem_read)
            result <= data_rdata;
    end

    // Set exactly for the WB cycle that follows EXE or MEM.
    always_ff @(posedge clk) begin
        if (reset)
            wb_en <= 1'b0;
        else
            wb_en <= dec.reg_write && ((step == cpu_pkg::STEP_MEM)
                     || (step == cpu_pkg::STEP_EXE && !dec.mem_read && !dec.mem_write));
    end

    assign rf_we       = wb_en;
    assign rf_waddr    = dec.dest;
    assign rf_wdata    = result;
    assign trace_we    = wb_en;
    assign trace_pc    = pc;
    assign trace_wnum  = dec.dest;
    assign trace_wdata = result;

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic              clk,
    input  logic              reset,
    output cpu_pkg::word_t    inst_addr,
    input  cpu_pkg::word_t    inst_rdata,
    output logic              data_we,
    output cpu_pkg::word_t    data_addr,
    output cpu_pkg::word_t    data_wdata,
    input  cpu_pkg::word_t    data_rdata,
    output cpu_pkg::word_t    trace_pc,
    output logic              trace_we,
    output cpu_pkg::reg_idx_t trace_wnum,
    output cpu_pkg::word_t    trace_wdata
);

    cpu_pkg::step_t    step;
    cpu_pkg::word_t    pc;
    cpu_pkg::word_t    inst;
    cpu_pkg::reg_idx_t raddr1, raddr2;
    cpu_pkg::word_t    rdata1, rdata2;
    cpu_pkg::word_t    alu_result;
    cpu_pkg::word_t    target;
    logic              taken;
    logic              rf_we;
    cpu_pkg::reg_idx_t rf_waddr;
    cpu_pkg::word_t    rf_wdata;

    dec_exe_if dec_bus ();

    assign inst_addr = pc;

    step_control step_control_inst (
        .clk(clk), .reset(reset), .inst_rdata(inst_rdata), .taken(taken),
        .target(target), .dec(dec_bus), .step(step), .pc(pc), .inst(inst)
    );

    inst_decoder inst_decoder_inst (
        .inst(inst), .dec(dec_bus), .raddr1(raddr1), .raddr2(raddr2)
    );

    regfile regfile_inst (
        .clk(clk), .raddr1(raddr1), .raddr2(raddr2), .we(rf_we), .waddr(rf_waddr),
        .wdata(rf_wdata), .rdata1(rdata1), .rdata2(rdata2)
    );

    exec_unit exec_unit_inst (
        .dec(dec_bus), .pc(pc), .step(step), .rdata1(rdata1), .rdata2(rdata2),
        .alu_result(alu_result), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .taken(taken), .target(target)
    );

    result_stage result_stage_inst (
        .clk(clk), .reset(reset), .dec(dec_bus), .step(step), .pc(pc),
        .alu_result(alu_result), .data_rdata(data_rdata), .rf_we(rf_we),
        .rf_waddr(rf_waddr), .rf_wdata(rf_wdata), .trace_pc(trace_pc),
        .trace_we(trace_we), .trace_wnum(trace_wnum), .trace_wdata(trace_wdata)
    );

endmodule

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;

    localparam int K_ADD = 0, K_SUB = 1, K_SLT = 2, K_SLTU = 3, K_NOR = 4, K_AND = 5;
    localparam int K_OR = 6, K_XOR = 7, K_SLLI = 8, K_SRLI = 9, K_SRAI = 10, K_ADDI = 11;
    localparam int K_LU12I = 12, K_LD = 13, K_ST = 14, K_JIRL = 15, K_B = 16, K_BL = 17;
    localparam int K_BEQ = 18, K_BNE = 19;

    logic clk, reset, data_we, trace_we;
    logic [31:0] inst_addr, inst_rdata, data_addr, data_wdata, data_rdata;
    logic [31:0] trace_pc, trace_wdata, last_addr, seed, c1, c2;
    logic [4:0] trace_wnum;
    logic [31:0] imem [64], dmem [64], mdm [64], mr [32];
    int pk [64], prd [64], prj [64], prk [64], pim [64];
    int n = 0, nexec = 0, cyc = 0, cnt = 0, checks = 0, errors = 0, limit = 100000;
    logic was_reset = 1'b0;
    logic [31:0] tq_pc [$], tq_data [$], sq_addr [$], sq_data [$];
    int tq_num [$], cq [$];

    cpu_top cpu_top_inst (
        .clk(clk), .reset(reset), .inst_addr(inst_addr), .inst_rdata(inst_rdata),
        .data_we(data_we), .data_addr(data_addr), .data_wdata(data_wdata),
        .data_rdata(data_rdata), .trace_pc(trace_pc), .trace_we(trace_we),
        .trace_wnum(trace_wnum), .trace_wdata(trace_wdata)
    );

    always #5 clk = ~clk;

    assign inst_rdata = imem[inst_addr[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_we === 1'b1)
            dmem[data_addr[7:2]] <= data_wdata;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    // ***********************************************************************
    // Program assembly.
    // ***********************************************************************
    task automatic emit(input int k, input int rd, input int rj, input int rk, input int im);
        logic [31:0] w;
        logic [4:0]  d, j, r;
        d = rd[4:0];
        j = rj[4:0];
        r = rk[4:0];
        case (k)
            K_ADD:   w = {12'h001, 5'h00, r, j, d};
            K_SUB:   w = {12'h001, 5'h02, r, j, d};
            K_SLT:   w = {12'h001, 5'h04, r, j, d};
            K_SLTU:  w = {12'h001, 5'h05, r, j, d};
            K_NOR:   w = {12'h001, 5'h08, r, j, d};
            K_AND:   w = {12'h001, 5'h09, r, j, d};
            K_OR:    w = {12'h001, 5'h0a, r, j, d};
            K_XOR:   w = {12'h001, 5'h0b, r, j, d};
            K_SLLI:  w = {12'h004, 5'h01, im[4:0], j, d};
            K_SRLI:  w = {12'h004, 5'h09, im[4:0], j, d};
            K_SRAI:  w = {12'h004, 5'h11, im[4:0], j, d};
            K_ADDI:  w = {6'h00, 4'ha, im[11:0], j, d};
            K_LU12I: w = {7'h0a, im[19:0], d};
            K_LD:    w = {6'h0a, 4'h2, im[11:0], j, d};
            K_ST:    w = {6'h0a, 4'h6, im[11:0], j, d};
            K_JIRL:  w = {6'h13, im[15:0], j, d};
            K_B:     w = {6'h14, im[15:0], im[25:16]};
            K_BL:    w = {6'h15, im[15:0], im[25:16]};
            K_BEQ:   w = {6'h16, im[15:0], j, d};
            default: w = {6'h17, im[15:0], j, d};
        endcase
        imem[n] = w;
        pk[n] = k;
        prd[n] = rd;
        prj[n] = rj;
        prk[n] = rk;
        pim[n] = im;
        n++;
    endtask

    task automatic load_const(input int rd, input logic [31:0] c);
        logic [31:0] hi;
        hi = (c + 32'h800) >> 12;
        emit(K_LU12I, rd, 0, 0, int'(hi[19:0]));
        emit(K_ADDI, rd, rd, 0, int'($signed(c[11:0])));
    endtask

    task automatic write_reg(input int rd, input logic [31:0] v, input logic [31:0] pc);
        if (rd != 0)
            mr[rd] = v;
        tq_pc.push_back(pc);
        tq_num.push_back(rd);
        tq_data.push_back(v);
    endtask

    // The reference model stops at the branch to itself.
    task automatic run_model();
        int i;
        int cyc_n;
        logic [31:0] a, b, pcv, npc, addr, offs;
        i = 0;
        while (!(pk[i] == K_B && pim[i] == 0)) begin
            pcv = `CPU_RESET_PC + 32'(i * 4);
            a = mr[prj[i]];
            b = mr[prk[i]];
            npc = pcv + 32'd4;
            offs = 32'(pim[i]) << 2;
            addr = a + 32'(pim[i]);
            cyc_n = 4;
            case (pk[i])
                K_ADD:   write_reg(prd[i], a + b, pcv);
                K_SUB:   write_reg(prd[i], a - b, pcv);
                K_SLT:   write_reg(prd[i], {31'b0, $signed(a) < $signed(b)}, pcv);
                K_SLTU:  write_reg(prd[i], {31'b0, a < b}, pcv);
                K_NOR:   write_reg(prd[i], ~(a | b), pcv);
                K_AND:   write_reg(prd[i], a & b, pcv);
                K_OR:    write_reg(prd[i], a | b, pcv);
                K_XOR:   write_reg(prd[i], a ^ b, pcv);
                K_SLLI:  write_reg(prd[i], a << pim[i][4:0], pcv);
                K_SRLI:  write_reg(prd[i], a >> pim[i][4:0], pcv);
                K_SRAI:  write_reg(prd[i], 32'($signed(a) >>> pim[i][4:0]), pcv);
                K_ADDI:  write_reg(prd[i], addr, pcv);
                K_LU12I: write_reg(prd[i], {pim[i][19:0], 12'h000}, pcv);
                K_LD: begin
                    write_reg(prd[i], mdm[addr[7:2]], pcv);
                    cyc_n = 5;
                end
                K_ST: begin
                    mdm[addr[7:2]] = mr[prd[i]];
                    sq_addr.push_back(addr);
                    sq_data.push_back(mr[prd[i]]);
                end
                K_JIRL: begin
                    npc = a + offs;
                    write_reg(prd[i], pcv + 32'd4, pcv);
                end
                K_BL: begin
                    npc = pcv + offs;
                    write_reg(int'(`CPU_LINK_REG), pcv + 32'd4, pcv);
                end
                K_B: begin
                    npc = pcv + offs;
                    cyc_n = 2;
                end
                default: begin
                    if ((a == mr[prd[i]]) == (pk[i] == K_BEQ))
                        npc = pcv + offs;
                    cyc_n = 2;
                end
            endcase
            cq.push_back(cyc_n);
            nexec++;
            i = int'((npc - `CPU_RESET_PC) >> 2);
        end
    endtask

    // ***********************************************************************
    // Monitors and timeout.
    // ***********************************************************************
    always @(posedge clk) begin
        if (cyc > 0 && (reset || was_reset)) begin
            check("reset trace_we", 32'(0), 32'(trace_we));
            check("reset data_we", 32'(0), 32'(data_we));
            check("reset inst_addr", `CPU_RESET_PC, inst_addr);
        end
        if (trace_we === 1'b1) begin
            assert (tq_pc.size() > 0) else begin
                errors++;
                $display("Register write seen after the model ran out of records");
            end
            if (tq_pc.size() > 0) begin
                check("trace pc", tq_pc.pop_front(), trace_pc);
                check("trace wnum", 32'(tq_num.pop_front()), 32'(trace_wnum));
                check("trace wdata", tq_data.pop_front(), trace_wdata);
            end
        end
        if (data_we === 1'b1) begin
            assert (sq_addr.size() > 0) else begin
                errors++;
                $display("Store seen that the model does not expect");
            end
            if (sq_addr.size() > 0) begin
                check("store addr", sq_addr.pop_front(), data_addr);
                check("store data", sq_data.pop_front(), data_wdata);
            end
        end
        // The -1 start absorbs the IDLE cycle after reset.
        if (reset) begin
            cnt = -1;
            last_addr = inst_addr;
        end else if (inst_addr != last_addr) begin
            if (cq.size() > 0)
                check("step cycles", 32'(cq.pop_front()), 32'(cnt));
            cnt = 1;
            last_addr = inst_addr;
        end else begin
            cnt++;
        end
        was_reset = reset;
        cyc++;
        if (cyc > limit) begin
            $display("Timeout after %0d cycles, %0d register writes never seen", cyc,
                     tq_pc.size());
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        seed = 32'h7010_16a6;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
            dmem[i] = 32'(i) * 32'h9e37_79b9 ^ 32'h5a5a_0000;
            mdm[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++)
            mr[i] = 32'h0;
        seed = lcg_next(seed);
        c1 = seed;
        seed = lcg_next(seed);
        c2 = seed | 32'h8000_0000;
        load_const(4, c1);
        load_const(5, c2);
        for (int k = K_ADD; k <= K_XOR; k++)
            emit(k, 7 + k, 4, 5, 0);
        emit(K_SLLI, 15, 4, 0, 7);
        emit(K_SRLI, 16, 5, 0, 13);
        emit(K_SRAI, 17, 5, 0, 13);
        emit(K_ADDI, 20, 0, 0, 'h40);
        emit(K_ST, 7, 20, 0, 0);
        emit(K_ST, 8, 20, 0, 8);
        emit(K_LD, 21, 20, 0, 0);
        emit(K_LD, 22, 20, 0, 8);
        emit(K_LD, 23, 20, 0, 4);
        emit(K_BEQ, 4, 4, 0, 2);
        emit(K_ADDI, 24, 0, 0, 1);
        emit(K_BNE, 4, 4, 0, 2);
        emit(K_ADDI, 24, 0, 0, 2);
        emit(K_BEQ, 5, 4, 0, 2);
        emit(K_BNE, 5, 4, 0, 2);
        emit(K_ADDI, 25, 0, 0, 3);
        emit(K_B, 0, 0, 0, 2);
        emit(K_ADDI, 25, 0, 0, 4);
        emit(K_BL, 0, 0, 0, 2);
        emit(K_ADDI, 28, 0, 0, 5);
        emit(K_JIRL, 27, 1, 0, 3);
        emit(K_ADDI, 28, 0, 0, 6);
        emit(K_ADD, 0, 4, 5, 0);
        emit(K_ADD, 29, 0, 4, 0);
        emit(K_B, 0, 0, 0, 0);
        run_model();
        limit = 16 + 5 * nexec + 100;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        while (tq_pc.size() > 0 || sq_addr.size() > 0 || cq.size() > 0)
            @(posedge clk);
        repeat (3) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/cpu_pkg.sv
common/dec_exe_if.sv
decode/inst_decoder.sv
execute/exec_unit.sv
logic/regfile.sv
logic/step_control.sv
logic/result_stage.sv
cpu_top.sv
tests/tb_cpu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = tb_cpu
FILELIST  = tb.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SRCS      = $(shell grep -v '^+' $(FILELIST)) common/cpu_settings.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJDIR)
